// ==== sources.f ====
hdl/dsc_pkg.sv
hdl/dsc_fetch.sv
hdl/dsc_decode.sv
hdl/dsc_queue.sv
hdl/dsc_dispatch.sv
hdl/dsc_manager.sv
testbench/dsc_manager_sva.sv
testbench/dsc_manager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds dsc_manager_tb with Verilator and runs it; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dsc_manager_tb \
    -f sources.f --Mdir obj_dir -o dsc_manager_sim &&
./obj_dir/dsc_manager_sim ||
{ echo "simulation build or run failed" >&2; exit 1; }

// ==== testbench/dsc_manager_tb.sv ====
/*
 * Memory and engine models for dsc_manager, driven from a table of descriptor chains.
 * Every chain keeps its valid stop descriptor in its last block; rows may share addresses
 * only where they describe the same blocks.
 */
`timescale 1ns/10ps

module dsc_manager_tb;

    localparam int NROWS       = 5;
    localparam int IDLE_CYCLES = 20;

    logic                       clk           = 1'b0;
    logic                       resetn;
    logic                       start;
    logic [dsc_pkg::ADDR_W-1:0] init_addr;
    logic [dsc_pkg::ADJ_W-1:0]  init_size;
    logic                       rd_valid;
    logic [dsc_pkg::ADDR_W-1:0] rd_addr;
    logic                       rd_first;
    logic                       rd_last;
    logic                       rd_ready      = 1'b0;
    logic                       rd_data_valid = 1'b0;
    logic [dsc_pkg::DSC_W-1:0]  rd_data       = '0;
    logic                       rd_data_last  = 1'b0;
    logic                       eng_write;
    logic [dsc_pkg::BODY_W-1:0] eng_dsc_body;
    logic [dsc_pkg::ID_W-1:0]   eng_dsc_id;
    logic                       eng_buf_full  = 1'b0;
    logic                       channel_done;

    // one row per test with up to three chained blocks
    // adj is the descriptor count minus one
    string                      t_name  [NROWS] = '{"single_block", "chaining",
                                                    "invalid_magic", "back_pressure", "restart"};
    logic [dsc_pkg::ADDR_W-1:0] t_addr  [NROWS][3] = '{
        '{64'h0000_0000_0000_1000, 64'h0, 64'h0},
        '{64'h0000_0001_0000_2000, 64'h0000_0000_0000_3400, 64'h0000_0002_8000_0000},
        '{64'h0000_0000_0000_5000, 64'h0000_0000_0000_4000, 64'h0},
        '{64'h0000_0000_ffff_ff00, 64'h0000_0003_0000_0040, 64'h0},
        '{64'h0000_0000_0000_1000, 64'h0, 64'h0}};
    logic [dsc_pkg::ADJ_W-1:0]  t_adj   [NROWS][3] = '{'{6'd7, 6'd0, 6'd0},
        '{6'd3, 6'd5, 6'd2}, '{6'd5, 6'd4, 6'd0}, '{6'd15, 6'd9, 6'd0}, '{6'd7, 6'd0, 6'd0}};
    // bit i set means descriptor i of the block has a wrong magic
    logic [15:0]                t_bad   [NROWS][3] = '{'{16'h0, 16'h0, 16'h0},
        '{16'h0, 16'h0, 16'h0}, '{16'h0032, 16'h0005, 16'h0}, '{16'h0, 16'h0, 16'h0},
        '{16'h0, 16'h0, 16'h0}};
    int                         t_nblk  [NROWS] = '{1, 3, 2, 2, 1};
    int                         t_stop  [NROWS] = '{7, 2, 4, 9, 7};
    int                         t_count [NROWS] = '{8, 13, 6, 26, 8};
    logic                       t_stress[NROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    logic                       t_reset [NROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

    logic [dsc_pkg::DSC_W-1:0]  mem_model   [logic [dsc_pkg::ADDR_W-1:0]];
    logic                       first_model [logic [dsc_pkg::ADDR_W-1:0]];
    logic                       last_model  [logic [dsc_pkg::ADDR_W-1:0]];
    logic [dsc_pkg::ADDR_W-1:0] pend_addr [$];
    logic                       pend_last [$];
    int                         pend_due  [$];
    logic [dsc_pkg::BODY_W-1:0] exp_body  [$];
    logic                       exp_done  [$];
    int                         last_due    = 0;
    int                         got         = 0;
    int                         cycle_cnt   = 0;
    int                         cycle_limit = 0;
    logic                       stress      = 1'b0;
    logic [31:0]                lfsr        = 32'hf329b04a;
    string                      cur_name    = "none";

    dsc_manager dut0 (.*);

    bind dsc_manager dsc_manager_sva sva0 (
        .clk          (clk),
        .resetn       (resetn),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_addr      (rd_addr),
        .rd_first     (rd_first),
        .rd_last      (rd_last),
        .head_valid   (head_valid),
        .eng_buf_full (eng_buf_full),
        .eng_dsc_body (eng_dsc_body),
        .eng_dsc_id   (eng_dsc_id)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // fibonacci with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [159:0] payload(input logic [dsc_pkg::ADDR_W-1:0] addr);
        logic [159:0] p;
        for (int k = 0; k < 5; k++) begin
            p[k*32 +: 32] = (addr[31:0] ^ {addr[47:32], addr[63:48]}) * 32'(2 * k + 3)
                            + 32'(k) * 32'h9e37_79b9;
        end
        return p;
    endfunction

    function automatic logic [dsc_pkg::DSC_W-1:0] make_desc(input int row, input int blk,
                                                            input int idx);
        logic [dsc_pkg::DSC_W-1:0]  d;
        logic [dsc_pkg::ADDR_W-1:0] addr;
        logic                       last;
        logic                       final_blk;
        logic                       bad;
        addr      = t_addr[row][blk] + dsc_pkg::ADDR_W'(idx * dsc_pkg::BEAT_BYTES);
        last      = idx == int'(t_adj[row][blk][3:0]);
        final_blk = blk == t_nblk[row] - 1;
        bad       = t_bad[row][blk][idx];
        d         = '0;
        d[dsc_pkg::BODY_W-1:32] = payload(addr);
        d[dsc_pkg::MAGIC_MSB:dsc_pkg::MAGIC_LSB] = bad ? 16'hdead : dsc_pkg::DSC_MAGIC;
        // bad descriptors carry stop too and decode must ignore it
        d[dsc_pkg::STOP_BIT] = bad | (final_blk & (idx == t_stop[row]));
        if (last && !final_blk) begin
            d[dsc_pkg::NEXT_LSB +: dsc_pkg::ADDR_W] = t_addr[row][blk + 1];
            d[dsc_pkg::ADJ_LSB +: dsc_pkg::ADJ_W]   = t_adj[row][blk + 1];
        end else if (!last) begin
            d[dsc_pkg::NEXT_LSB +: dsc_pkg::ADDR_W] = ~addr;
            d[dsc_pkg::ADJ_LSB +: dsc_pkg::ADJ_W]   = 6'h3f;
        end
        return d;
    endfunction

    task automatic build_memory();
        int                         total;
        logic [dsc_pkg::ADDR_W-1:0] a;
        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            for (int b = 0; b < t_nblk[r]; b++) begin
                for (int i = 0; i <= int'(t_adj[r][b][3:0]); i++) begin
                    a = t_addr[r][b] + dsc_pkg::ADDR_W'(i * dsc_pkg::BEAT_BYTES);
                    mem_model[a]   = make_desc(r, b, i);
                    first_model[a] = i == 0;
                    last_model[a]  = i == int'(t_adj[r][b][3:0]);
                    total++;
                end
            end
        end
        cycle_limit = 64 * total + 200;
    endtask

    // valid descriptors in chain order with done only on the stop one
    task automatic build_expected(input int row);
        logic [dsc_pkg::DSC_W-1:0] d;
        exp_body.delete();
        exp_done.delete();
        for (int b = 0; b < t_nblk[row]; b++) begin
            for (int i = 0; i <= int'(t_adj[row][b][3:0]); i++) begin
                if (!t_bad[row][b][i]) begin
                    d = make_desc(row, b, i);
                    exp_body.push_back(d[dsc_pkg::BODY_W-1:0]);
                    exp_done.push_back(b == t_nblk[row] - 1 && i == t_stop[row]);
                end
            end
        end
        if (exp_body.size() != t_count[row]) begin
            fail_run($sformatf("Table row %s holds %0d valid descriptors instead of %0d",
                               t_name[row], exp_body.size(), t_count[row]));
        end
    endtask

    task automatic check_body(input logic [dsc_pkg::BODY_W-1:0] exp_val,
                              input logic [dsc_pkg::BODY_W-1:0] act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("Mismatch %s body %0d: expected %h, actual %h",
                               cur_name, got, exp_val, act_val));
        end
    endtask

    task automatic check_id(input logic [dsc_pkg::ID_W-1:0] exp_val,
                            input logic [dsc_pkg::ID_W-1:0] act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("Mismatch %s id %0d: expected %0d, actual %0d",
                               cur_name, got, exp_val, act_val));
        end
    endtask

    task automatic check_done(input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("Mismatch %s channel_done %0d: expected %b, actual %b",
                               cur_name, got, exp_val, act_val));
        end
    endtask

    task automatic check_flag(input string flag, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            fail_run($sformatf("Mismatch %s %s at %h: expected %b, actual %b",
                               cur_name, flag, rd_addr, exp_val, act_val));
        end
    endtask

    // read requests and engine writes sampled mid-cycle
    always @(negedge clk) begin
        int lat;
        int due;
        if (resetn && rd_valid && rd_ready) begin
            if (!mem_model.exists(rd_addr)) begin
                fail_run($sformatf("Read request to %h lies outside every descriptor block",
                                   rd_addr));
            end else begin
                check_flag("rd_first", first_model[rd_addr], rd_first);
                check_flag("rd_last", last_model[rd_addr], rd_last);
                lat = 1 + int'(lfsr_bit());
                lat = lat + 2 * int'(lfsr_bit());
                due = cycle_cnt + 1 + lat;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(rd_addr);
                pend_last.push_back(rd_last);
                pend_due.push_back(due);
            end
        end
        if (eng_write) begin
            if (got >= exp_body.size()) begin
                fail_run($sformatf("Engine write in %s after all %0d expected descriptors",
                                   cur_name, exp_body.size()));
            end else begin
                check_body(exp_body[got], eng_dsc_body);
                check_id(dsc_pkg::ID_W'(got), eng_dsc_id);
                check_done(exp_done[got], channel_done);
                got++;
            end
        end
    end

    always @(negedge clk) begin
        if (cycle_cnt > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles in %s: no stop descriptor arrived",
                               cycle_cnt, cur_name));
        end
    end

    // ready, full and in-order memory responses
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (stress) begin
            rd_ready     <= lfsr_bit();
            eng_buf_full <= lfsr_bit();
        end else begin
            rd_ready     <= 1'b1;
            eng_buf_full <= 1'b0;
        end
        if (pend_addr.size() > 0 && pend_due[0] <= cycle_cnt) begin
            rd_data_valid <= 1'b1;
            rd_data       <= mem_model[pend_addr[0]];
            rd_data_last  <= pend_last[0];
            void'(pend_addr.pop_front());
            void'(pend_last.pop_front());
            void'(pend_due.pop_front());
        end else begin
            rd_data_valid <= 1'b0;
        end
    end

    initial begin
        resetn    = 1'b0;
        start     = 1'b0;
        init_addr = '0;
        init_size = '0;
        build_memory();
        for (int r = 0; r < NROWS; r++) begin
            @(posedge clk);
            start     <= 1'b0;
            stress    <= t_stress[r];
            init_addr <= t_addr[r][0];
            init_size <= t_adj[r][0];
            if (t_reset[r]) begin
                resetn <= 1'b0;
                repeat (5) @(posedge clk);
                resetn <= 1'b1;
            end
            repeat (2) @(posedge clk);
            cur_name = t_name[r];
            build_expected(r);
            got = 0;
            start <= 1'b1;
            while (got < exp_body.size()) begin
                @(posedge clk);
            end
            // quiet period catches extra writes
            repeat (IDLE_CYCLES) @(posedge clk);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== testbench/dsc_manager_sva.sv ====
/*
 * Handshake checks on the read request and engine ports, bound into dsc_manager.
 * The engine hold check assumes no restart while descriptors wait in the queue.
 */
`timescale 1ns/10ps

module dsc_manager_sva (
    input logic                       clk,
    input logic                       resetn,
    input logic                       rd_valid,
    input logic                       rd_ready,
    input logic [dsc_pkg::ADDR_W-1:0] rd_addr,
    input logic                       rd_first,
    input logic                       rd_last,
    input logic                       head_valid,
    input logic                       eng_buf_full,
    input logic [dsc_pkg::BODY_W-1:0] eng_dsc_body,
    input logic [dsc_pkg::ID_W-1:0]   eng_dsc_id
);

    // stalled request keeps valid and address
    rd_hold_a: assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
        else $error("read request changed or dropped while rd_ready was low");

    rd_flags_a: assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && !rd_ready |=> $stable(rd_first) && $stable(rd_last))
        else $error("read flags changed while rd_ready was low");

    // a full engine leaves the head descriptor and its id in place
    eng_hold_a: assert property (@(posedge clk) disable iff (!resetn)
        head_valid && eng_buf_full |=> head_valid && $stable(eng_dsc_body) &&
            $stable(eng_dsc_id))
        else $error("head descriptor lost or changed while the engine buffer was full");

endmodule

// ==== hdl/dsc_manager.sv ====
/*
 * Descriptor manager for one channel and one engine.
 * Read data has no back-pressure; every valid beat must belong to the current block.
 */
`timescale 1ns/10ps

module dsc_manager (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  logic [dsc_pkg::ADDR_W-1:0] init_addr,
    input  logic [dsc_pkg::ADJ_W-1:0]  init_size,
    output logic                       rd_valid,
    output logic [dsc_pkg::ADDR_W-1:0] rd_addr,
    output logic                       rd_first,
    output logic                       rd_last,
    input  logic                       rd_ready,
    input  logic                       rd_data_valid,
    input  logic [dsc_pkg::DSC_W-1:0]  rd_data,
    input  logic                       rd_data_last,
    output logic                       eng_write,
    output logic [dsc_pkg::BODY_W-1:0] eng_dsc_body,
    output logic [dsc_pkg::ID_W-1:0]   eng_dsc_id,
    input  logic                       eng_buf_full,
    output logic                       channel_done
);

    logic                       restart;
    logic                       push;
    logic [dsc_pkg::DSC_W-1:0]  push_data;
    logic                       block_end;
    logic [dsc_pkg::ADDR_W-1:0] chain_addr;
    logic [dsc_pkg::ADJ_W-1:0]  chain_adj;
    logic                       chain_stop;
    logic [dsc_pkg::QCNT_W-1:0] free_count;
    logic [dsc_pkg::DSC_W-1:0]  head_data;
    logic                       head_valid;
    logic                       pop;

    dsc_fetch fetch0 (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .init_addr  (init_addr),
        .init_size  (init_size),
        .rd_ready   (rd_ready),
        .block_end  (block_end),
        .chain_addr (chain_addr),
        .chain_adj  (chain_adj),
        .chain_stop (chain_stop),
        .free_count (free_count),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_first   (rd_first),
        .rd_last    (rd_last),
        .restart    (restart)
    );

    dsc_decode decode0 (
        .clk           (clk),
        .resetn        (resetn),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_data_last  (rd_data_last),
        .push          (push),
        .push_data     (push_data),
        .block_end     (block_end),
        .chain_addr    (chain_addr),
        .chain_adj     (chain_adj),
        .chain_stop    (chain_stop)
    );

    dsc_queue queue0 (
        .clk        (clk),
        .resetn     (resetn),
        .restart    (restart),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .head_data  (head_data),
        .head_valid (head_valid),
        .free_count (free_count)
    );

    dsc_dispatch dispatch0 (
        .clk          (clk),
        .resetn       (resetn),
        .restart      (restart),
        .head_data    (head_data),
        .head_valid   (head_valid),
        .eng_buf_full (eng_buf_full),
        .pop          (pop),
        .eng_write    (eng_write),
        .eng_dsc_body (eng_dsc_body),
        .eng_dsc_id   (eng_dsc_id),
        .channel_done (channel_done)
    );

endmodule

// ==== hdl/dsc_dispatch.sv ====
/*
 * Hands the queue head to the engine whenever the engine buffer is not full.
 * Outputs are combinational from the head; ids restart at 0 on every start.
 */
`timescale 1ns/10ps

module dsc_dispatch (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       restart,
    input  logic [dsc_pkg::DSC_W-1:0]  head_data,
    input  logic                       head_valid,
    input  logic                       eng_buf_full,
    output logic                       pop,
    output logic                       eng_write,
    output logic [dsc_pkg::BODY_W-1:0] eng_dsc_body,
    output logic [dsc_pkg::ID_W-1:0]   eng_dsc_id,
    output logic                       channel_done
);

    logic [dsc_pkg::ID_W-1:0] id_cnt;

    // engine takes the descriptor in the write cycle
    assign eng_write    = head_valid & ~eng_buf_full;
    assign pop          = eng_write;
    assign eng_dsc_body = head_data[dsc_pkg::BODY_W-1:0];
    assign eng_dsc_id   = id_cnt;
    assign channel_done = eng_write & head_data[dsc_pkg::STOP_BIT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            id_cnt <= '0;
        end else if (restart) begin
            id_cnt <= '0;
        end else if (eng_write) begin
            id_cnt <= id_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/dsc_queue.sv ====
/*
 * Circular descriptor store of QUEUE_DEPTH entries, emptied by restart.
 * Has no overflow guard and relies on fetch holding off until free_count covers a block.
 */
`timescale 1ns/10ps

module dsc_queue (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       restart,
    input  logic                       push,
    input  logic [dsc_pkg::DSC_W-1:0]  push_data,
    input  logic                       pop,
    output logic [dsc_pkg::DSC_W-1:0]  head_data,
    output logic                       head_valid,
    output logic [dsc_pkg::QCNT_W-1:0] free_count
);

    logic [dsc_pkg::DSC_W-1:0]                 mem [dsc_pkg::QUEUE_DEPTH];
    logic [$clog2(dsc_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(dsc_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [dsc_pkg::QCNT_W-1:0]                count;
    logic                                      do_pop;

    assign do_pop = pop & head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (restart) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_data  = mem[rd_ptr];
    assign head_valid = count != '0;
    assign free_count = dsc_pkg::QCNT_W'(dsc_pkg::QUEUE_DEPTH) - count;

endmodule

// ==== hdl/dsc_decode.sv ====
/*
 * Checks the magic of each returned descriptor; pushes are one cycle behind the read data.
 * Chain fields come from the last beat of a block even when its magic is bad.
 */
`timescale 1ns/10ps

module dsc_decode (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       rd_data_valid,
    input  logic [dsc_pkg::DSC_W-1:0]  rd_data,
    input  logic                       rd_data_last,
    output logic                       push,
    output logic [dsc_pkg::DSC_W-1:0]  push_data,
    output logic                       block_end,
    output logic [dsc_pkg::ADDR_W-1:0] chain_addr,
    output logic [dsc_pkg::ADJ_W-1:0]  chain_adj,
    output logic                       chain_stop
);

    logic                      beat_valid_q;
    logic                      beat_last_q;
    logic [dsc_pkg::DSC_W-1:0] beat_q;
    logic                      magic_ok;
    logic                      stop_acc;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            beat_valid_q <= 1'b0;
            beat_last_q  <= 1'b0;
        end else begin
            beat_valid_q <= rd_data_valid;
            beat_last_q  <= rd_data_valid & rd_data_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data_valid) begin
            beat_q <= rd_data;
        end
    end

    assign magic_ok  = beat_q[dsc_pkg::MAGIC_MSB:dsc_pkg::MAGIC_LSB] == dsc_pkg::DSC_MAGIC;
    assign push      = beat_valid_q & magic_ok;
    assign push_data = beat_q;

    // stop seen on any valid descriptor of the current block
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            stop_acc <= 1'b0;
        end else if (block_end) begin
            stop_acc <= 1'b0;
        end else if (push && beat_q[dsc_pkg::STOP_BIT]) begin
            stop_acc <= 1'b1;
        end
    end

    assign block_end  = beat_valid_q & beat_last_q;
    assign chain_addr = beat_q[dsc_pkg::NEXT_LSB +: dsc_pkg::ADDR_W];
    assign chain_adj  = beat_q[dsc_pkg::ADJ_LSB +: dsc_pkg::ADJ_W];
    assign chain_stop = stop_acc | (push & beat_q[dsc_pkg::STOP_BIT]);

endmodule

// ==== hdl/dsc_fetch.sv ====
/*
 * Read sequencer for descriptor blocks. A new start edge is only safe with no read in flight.
 * One beat per descriptor; blocks are requested only when the queue can take the whole block.
 */
`timescale 1ns/10ps

module dsc_fetch (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  logic [dsc_pkg::ADDR_W-1:0] init_addr,
    input  logic [dsc_pkg::ADJ_W-1:0]  init_size,
    input  logic                       rd_ready,
    input  logic                       block_end,
    input  logic [dsc_pkg::ADDR_W-1:0] chain_addr,
    input  logic [dsc_pkg::ADJ_W-1:0]  chain_adj,
    input  logic                       chain_stop,
    input  logic [dsc_pkg::QCNT_W-1:0] free_count,
    output logic                       rd_valid,
    output logic [dsc_pkg::ADDR_W-1:0] rd_addr,
    output logic                       rd_first,
    output logic                       rd_last,
    output logic                       restart
);

    logic                                start_q;
    logic [dsc_pkg::ADDR_W-1:0]          base_addr;
    logic [dsc_pkg::ADJ_W-1:0]           adj_cnt;
    logic                                stopped;
    logic                                waiting;
    logic [dsc_pkg::BEAT_W-1:0]          beat_cnt;
    logic [$clog2(dsc_pkg::BLOCK_MAX):0] need;
    logic                                request;
    logic                                beat_done;

    assign restart = start & ~start_q;

    // slots needed for the next block
    assign need    = {1'b0, adj_cnt[dsc_pkg::BEAT_W-1:0]} + 1'b1;
    assign request = ~waiting & ~stopped & start_q &
                     (free_count >= dsc_pkg::QCNT_W'(need));

    assign rd_addr   = base_addr + dsc_pkg::ADDR_W'(beat_cnt) *
                       dsc_pkg::ADDR_W'(dsc_pkg::BEAT_BYTES);
    assign rd_first  = rd_valid & (beat_cnt == '0);
    assign rd_last   = rd_valid & (beat_cnt == adj_cnt[dsc_pkg::BEAT_W-1:0]);
    assign beat_done = rd_valid & rd_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    // chain state reloaded on start and at every block end
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            base_addr <= '0;
            adj_cnt   <= '0;
            stopped   <= 1'b0;
            waiting   <= 1'b0;
        end else if (restart) begin
            base_addr <= init_addr;
            adj_cnt   <= init_size;
            stopped   <= 1'b0;
            waiting   <= 1'b0;
        end else if (block_end) begin
            base_addr <= chain_addr;
            adj_cnt   <= chain_adj;
            stopped   <= chain_stop;
            waiting   <= 1'b0;
        end else if (request) begin
            waiting   <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd_valid <= 1'b0;
            beat_cnt <= '0;
        end else if (restart) begin
            rd_valid <= 1'b0;
            beat_cnt <= '0;
        end else if (request) begin
            rd_valid <= 1'b1;
            beat_cnt <= '0;
        end else if (beat_done) begin
            if (rd_last) begin
                rd_valid <= 1'b0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/dsc_pkg.sv ====
/*
 * Field positions and sizes for the single-channel descriptor manager.
 * A block holds at most 16 descriptors; only the low 4 bits of the adjacent count are used.
 */
package dsc_pkg;

    // descriptor word and bus widths
    localparam int DSC_W       = 256;
    localparam int ADDR_W      = 64;
    localparam int ID_W        = 30;
    localparam int BODY_W      = 192;

    // magic check
    localparam int MAGIC_LSB   = 16;
    localparam int MAGIC_MSB   = 31;
    localparam logic [15:0] DSC_MAGIC = 16'had4b;

    // control bits of a descriptor
    localparam int STOP_BIT    = 0;
    localparam int ADJ_LSB     = 8;
    localparam int ADJ_W       = 6;

    // next block address, carried in the top 64 bits
    localparam int NEXT_LSB    = 192;

    // fetch sizing
    localparam int BEAT_BYTES  = 32;
    localparam int BLOCK_MAX   = 16;
    localparam int BEAT_W      = 4;

    // descriptor queue
    localparam int QUEUE_DEPTH = 32;
    localparam int QCNT_W      = 6;

endpackage
